//--- kd_pkg.sv
// Shared widths, coordinate and patch types, node config word and leaf index type
`default_nettype none

package kd_pkg;

  // Coordinate geometry
  localparam int COORD_W  = 11;  // Signed coordinate width
  localparam int NUM_DIMS = 5;   // Coordinates per patch
  localparam int DIM_W    = 3;   // Enough to select 5 dims, 5..7 unused

  // Host config word width, one word per internal node
  localparam int CFG_W = 22;

  // Bits between median and dim that carry nothing
  localparam int CFG_PAD_W = CFG_W - COORD_W - DIM_W;

  // Leaf index width, covers depths up to 8
  localparam int LEAF_W = 8;

  // One signed coordinate
  typedef logic signed [COORD_W-1:0] kd_coord_t;

  // Full patch, coordinate 0 sits in the low bits
  typedef kd_coord_t [NUM_DIMS-1:0] kd_patch_t;

  // Node configuration word as the host streams it
  // Median on top, pad in the middle, split dim at the bottom
  typedef struct packed {
    kd_coord_t            median;  // Split value, signed
    logic [CFG_PAD_W-1:0] unused;  // Ignored by the node
    logic [DIM_W-1:0]     dim;     // Split dimension
  } kd_node_cfg_t;

  // Dimension held by a node that was never loaded
  // Selects coordinate value 0, so 0 < 0 fails and the patch goes right
  localparam logic [DIM_W-1:0] DIM_INVALID = 3'd7;

  // Leaf number, branch decisions MSB first, right = 1
  typedef logic [LEAF_W-1:0] kd_leaf_t;

endpackage

`default_nettype wire

//--- kd_internal_node.sv
// KD-tree internal node with stored split dim and median and left/right valid routing
`timescale 1ns/1ns
`default_nettype none

module kd_internal_node (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wen,          // One-hot write from the node writer
  input  kd_pkg::kd_node_cfg_t cfg,         // Shared config bus
  input  logic                valid,        // Patch reached this node
  input  kd_pkg::kd_patch_t   patch,        // Patch registered for this level
  output logic                valid_left,
  output logic                valid_right
);

  logic [kd_pkg::DIM_W-1:0] dim_q;      // Stored split dimension
  kd_pkg::kd_coord_t        median_q;   // Stored split value
  kd_pkg::kd_coord_t        sel_coord;  // Coordinate picked by dim_q
  logic                     go_left;

  // Config storage, new value seen by patches from the next cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dim_q    <= kd_pkg::DIM_INVALID;
      median_q <= '0;
    end else if (wen) begin
      dim_q    <= cfg.dim;
      median_q <= cfg.median;
    end
  end

  // Coordinate select
  always_comb begin
    if (dim_q < kd_pkg::NUM_DIMS) begin
      sel_coord = patch[dim_q];
    end else begin
      sel_coord = '0;  // Invalid dim reads as zero
    end
  end

  // Signed compare, both operands are signed types
  assign go_left = (sel_coord < median_q);

  // Exactly one side carries the valid bit
  assign valid_left  = valid & go_left;
  assign valid_right = valid & ~go_left;

endmodule

`default_nettype wire

//--- kd_node_writer.sv
// Breadth-first config write address counter and one-hot node write decoder
`timescale 1ns/1ns
`default_nettype none

module kd_node_writer #(
  parameter int DEPTH = 6
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     load_mode,  // Host is in load phase
  input  logic                     cfg_valid,  // One config word this cycle
  output logic [(1<<DEPTH)-2:0]    node_wen    // One bit per internal node
);

  localparam int NUM_NODES = (1 << DEPTH) - 1;
  localparam int ADDR_W    = DEPTH;  // Holds 0 .. NUM_NODES-1

  logic              accept;   // Word taken this edge
  logic [ADDR_W-1:0] wr_addr;  // Breadth-first node address, 0 is the root

  // Both enables must be high, there is no back-pressure
  assign accept = load_mode & cfg_valid;

  // Address steps once per accepted word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (accept) begin
      if (wr_addr == ADDR_W'(NUM_NODES - 1)) begin
        wr_addr <= '0;  // Wrap back to the root after the last node
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // One-hot decode of the current address
  always_comb begin
    for (int n = 0; n < NUM_NODES; n++) begin
      node_wen[n] = accept && (wr_addr == ADDR_W'(n));
    end
  end

endmodule

`default_nettype wire

//--- kd_search_tree.sv
// KD search tree with node array, per-level patch and valid pipeline, and leaf encoder
`timescale 1ns/1ns
`default_nettype none

module kd_search_tree #(
  parameter int DEPTH = 6
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [(1<<DEPTH)-2:0]  node_wen,    // One-hot node write enables
  input  kd_pkg::kd_node_cfg_t   cfg,         // Config word shared by all nodes
  input  logic                   patch_en,    // New patch this edge
  input  kd_pkg::kd_patch_t      patch,
  output kd_pkg::kd_leaf_t       leaf_index   // Leaf reached by the oldest patch
);

  localparam int NUM_NODES  = (1 << DEPTH) - 1;        // Internal nodes
  localparam int NUM_LEAVES = 1 << DEPTH;
  localparam int NUM_VALID  = (1 << (DEPTH + 1)) - 1;  // Nodes plus leaves

  // Valid bits in heap order over all levels
  // Level L position j sits at index 2^L-1+j
  // Children of node n sit at 2n+1 and 2n+2
  logic [NUM_VALID-1:0] valid_q;     // Registered valid per level
  logic [NUM_VALID-1:0] next_valid;  // Input side of valid_q

  // Patch copy for each node level only
  kd_pkg::kd_patch_t patch_q [DEPTH];

  // Root valid comes straight from the strobe
  assign next_valid[0] = patch_en;

  // Node array where each level reads its own patch register
  for (genvar lvl = 0; lvl < DEPTH; lvl++) begin : g_level
    for (genvar pos = 0; pos < (1 << lvl); pos++) begin : g_node
      localparam int N = (1 << lvl) - 1 + pos;  // Heap index of this node

      kd_internal_node node0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .wen         (node_wen[N]),
        .cfg         (cfg),
        .valid       (valid_q[N]),
        .patch       (patch_q[lvl]),
        .valid_left  (next_valid[2*N+1]),  // Left child is bit 2j of the next level
        .valid_right (next_valid[2*N+2])   // Right child is bit 2j+1
      );
    end
  end

  // Valid pipeline advances one level per clock
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= next_valid;
    end
  end

  // Patch pipeline travels alongside the valid bits
  always_ff @(posedge clk) begin
    patch_q[0] <= patch;  // Sampled every edge and qualified by the root valid
    for (int lvl = 1; lvl < DEPTH; lvl++) begin
      patch_q[lvl] <= patch_q[lvl-1];
    end
  end

  // Leaf encoder
  // Last level is one-hot or empty
  // Leaf position equals the decision bits
  always_comb begin
    leaf_index = '0;  // Nothing valid gives leaf 0
    for (int i = 0; i < NUM_LEAVES; i++) begin
      if (valid_q[NUM_NODES + i]) begin
        leaf_index = kd_pkg::kd_leaf_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

//--- kd_patch_classifier.sv
// Patch classifier top with config writer, search tree and result-valid delay line
`timescale 1ns/1ns
`default_nettype none

module kd_patch_classifier #(
  parameter int DEPTH = 6  // Tree levels of internal nodes
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load_mode,   // Config load phase level
  input  logic                 cfg_valid,   // Config word strobe
  input  kd_pkg::kd_node_cfg_t cfg_word,
  input  logic                 patch_en,    // Patch strobe, one per cycle max
  input  kd_pkg::kd_patch_t    patch,
  output kd_pkg::kd_leaf_t     leaf_index,
  output logic                 result_valid
);

  logic [(1<<DEPTH)-2:0] node_wen;  // Writer to tree, one bit per node
  logic [DEPTH:0]        en_dly;    // patch_en delay line, DEPTH+1 stages

  // Breadth-first config writer
  kd_node_writer #(
    .DEPTH (DEPTH)
  ) writer0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_mode (load_mode),
    .cfg_valid (cfg_valid),
    .node_wen  (node_wen)
  );

  // Pipelined tree, config word goes to every node
  kd_search_tree #(
    .DEPTH (DEPTH)
  ) tree0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .node_wen   (node_wen),
    .cfg        (cfg_word),
    .patch_en   (patch_en),
    .patch      (patch),
    .leaf_index (leaf_index)
  );

  // Stage 0 lines up with the root registers, stage DEPTH with the leaves
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      en_dly <= '0;
    end else begin
      en_dly <= {en_dly[DEPTH-1:0], patch_en};
    end
  end

  assign result_valid = en_dly[DEPTH];  // Fixed latency, gaps pass through

endmodule

`default_nettype wire

//--- tb_kd_vectors.svh
// Test patch table with phase tags, patch and row builders, random node config builder
`ifndef TB_KD_VECTORS_SVH
`define TB_KD_VECTORS_SVH

localparam logic [1:0] PH_EDGE  = 2'd0;  // Extremes, ties at zero
localparam logic [1:0] PH_BURST = 2'd1;  // Back-to-back patches
localparam logic [1:0] PH_GAP   = 2'd2;  // Holes in patch_en
localparam int         NUM_VEC  = 18;

// One table row
typedef struct packed {
  logic [1:0]        phase;  // Which group the row belongs to
  logic              en;     // Value for patch_en
  kd_pkg::kd_patch_t patch;
} vec_t;

vec_t vectors [NUM_VEC];

// Coordinate 0 goes to the low bits
function automatic kd_pkg::kd_patch_t make_patch(input int c0, c1, c2, c3, c4);
  kd_pkg::kd_patch_t p;
  p[0] = kd_pkg::kd_coord_t'(c0);
  p[1] = kd_pkg::kd_coord_t'(c1);
  p[2] = kd_pkg::kd_coord_t'(c2);
  p[3] = kd_pkg::kd_coord_t'(c3);
  p[4] = kd_pkg::kd_coord_t'(c4);
  return p;
endfunction

function automatic vec_t make_row(input logic [1:0] ph, input logic en,
                                  input int c0, c1, c2, c3, c4);
  vec_t v;
  v.phase = ph;
  v.en    = en;
  v.patch = make_patch(c0, c1, c2, c3, c4);
  return v;
endfunction

task automatic fill_table();
  vectors[0]  = make_row(PH_EDGE,  1'b1,     0,     0,     0,     0,     0);
  vectors[1]  = make_row(PH_EDGE,  1'b1, -1024, -1024, -1024, -1024, -1024);
  vectors[2]  = make_row(PH_EDGE,  1'b1,  1023,  1023,  1023,  1023,  1023);
  vectors[3]  = make_row(PH_EDGE,  1'b1,    -1,     1,    -1,     1,    -1);
  vectors[4]  = make_row(PH_EDGE,  1'b1,  1023, -1024,   512,  -512,     0);
  vectors[5]  = make_row(PH_EDGE,  1'b1,  -300,   700,  -900,    50,  1000);
  vectors[6]  = make_row(PH_BURST, 1'b1,   100,  -200,   300,  -400,   500);
  vectors[7]  = make_row(PH_BURST, 1'b1,  -650,   820,   -15,   240,  -999);
  vectors[8]  = make_row(PH_BURST, 1'b1,     7,    -7,    77,   -77,   777);
  vectors[9]  = make_row(PH_BURST, 1'b1,   900,  -850,   600,  -300,    10);
  vectors[10] = make_row(PH_BURST, 1'b1,  -128,   256,  -512,  1000, -1000);
  vectors[11] = make_row(PH_BURST, 1'b1,   333,  -444,   555,  -666,   111);
  vectors[12] = make_row(PH_GAP,   1'b1,   450,   -20,  -700,   880,   -60);
  vectors[13] = make_row(PH_GAP,   1'b0,     1,     2,     3,     4,     5);  // Must vanish
  vectors[14] = make_row(PH_GAP,   1'b1,  -410,   390,  -250,   650,  -830);
  vectors[15] = make_row(PH_GAP,   1'b0,     0,     0,     0,     0,     0);
  vectors[16] = make_row(PH_GAP,   1'b0,    -5,    -5,    -5,    -5,    -5);
  vectors[17] = make_row(PH_GAP,   1'b1,   820,  -760,   140,   -30,  -560);
endtask

// Random words for the next load, dims 5..7 left in on purpose
task automatic build_config();
  int r;
  for (int n = 0; n < NUM_NODES; n++) begin
    r = $random(seed);
    new_cfg[n].dim    = r[2:0];
    new_cfg[n].median = r[13:3];   // Full signed range
    new_cfg[n].unused = r[21:14];  // Junk the node ignores
  end
endtask

`endif

//--- tb_kd_patch_classifier.sv
// Testbench for the KD-tree patch classifier with tree walk model, table loop and compare tasks
`timescale 1ns/1ns
`default_nettype none

module tb_kd_patch_classifier;

  localparam int DEPTH     = 6;
  localparam int NUM_NODES = (1 << DEPTH) - 1;
  localparam int LATENCY   = DEPTH + 1;   // Drive edge to sampling edge
  localparam int WAIT_MAX  = DEPTH + 10;  // Cycles allowed for one wait

  logic                 clk;
  logic                 rst_n;
  logic                 load_mode;
  logic                 cfg_valid;
  kd_pkg::kd_node_cfg_t cfg_word;
  logic                 patch_en;
  kd_pkg::kd_patch_t    patch;
  kd_pkg::kd_leaf_t     leaf_index;
  logic                 result_valid;

  integer               seed;                  // $random state
  kd_pkg::kd_node_cfg_t model_cfg [NUM_NODES]; // What the nodes should hold
  kd_pkg::kd_node_cfg_t new_cfg [NUM_NODES];   // Words for the next load
  kd_pkg::kd_leaf_t     exp_leaf [$];          // Oldest first
  int                   exp_edge [$];          // Edge count where each result is due
  int                   edge_cnt;
  int                   err_cnt;
  int                   errs_before;
  int                   tests_pass;
  int                   tests_fail;

  `include "tb_kd_vectors.svh"

  kd_patch_classifier #(
    .DEPTH (DEPTH)
  ) dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_mode    (load_mode),
    .cfg_valid    (cfg_valid),
    .cfg_word     (cfg_word),
    .patch_en     (patch_en),
    .patch        (patch),
    .leaf_index   (leaf_index),
    .result_valid (result_valid)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50;
      clk = ~clk;
    end
  end

  // Walk from the root, right when coordinate >= median
  function automatic kd_pkg::kd_leaf_t model_leaf(input kd_pkg::kd_patch_t p);
    int                n;
    kd_pkg::kd_leaf_t  leaf;
    kd_pkg::kd_coord_t c;
    logic              right;
    n    = 0;
    leaf = '0;
    for (int lvl = 0; lvl < DEPTH; lvl++) begin
      if (int'(model_cfg[n].dim) < kd_pkg::NUM_DIMS) begin
        c = p[model_cfg[n].dim];
      end else begin
        c = '0;  // Invalid dim reads zero
      end
      right = !(c < model_cfg[n].median);
      leaf  = {leaf[kd_pkg::LEAF_W-2:0], right};  // First decision ends up MSB
      n     = 2 * n + 1 + int'(right);
    end
    return leaf;
  endfunction

  task automatic reset_model();
    for (int n = 0; n < NUM_NODES; n++) begin
      model_cfg[n]     = '0;
      model_cfg[n].dim = kd_pkg::DIM_INVALID;
    end
  endtask

  task automatic check_valid(input logic exp_v, input logic act_v, input string name);
    if (exp_v !== act_v) begin
      $display("mismatch at %0t ns: %s expected %0b actual %0b", $time, name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic check_leaf(input kd_pkg::kd_leaf_t exp_l, input kd_pkg::kd_leaf_t act_l,
                            input string name);
    if (exp_l !== act_l) begin
      $display("mismatch at %0t ns: %s expected %0d actual %0d", $time, name, exp_l, act_l);
      err_cnt++;
    end
  endtask

  // Outputs are settled at the falling edge
  task automatic sample_outputs();
    logic due;
    due = (exp_edge.size() > 0) && (exp_edge[0] == edge_cnt);
    check_valid(due, result_valid, "result_valid");  // Also catches stray results
    if (due) begin
      if (result_valid) begin
        check_leaf(exp_leaf[0], leaf_index, "leaf_index");
      end
      void'(exp_leaf.pop_front());
      void'(exp_edge.pop_front());
    end
  endtask

  // One clock: drive at the rising edge, check at the falling edge
  task automatic apply_cycle(input logic en, input kd_pkg::kd_patch_t p);
    @(posedge clk);
    edge_cnt++;
    patch_en <= en;
    patch    <= p;
    if (en) begin
      exp_leaf.push_back(model_leaf(p));
      exp_edge.push_back(edge_cnt + LATENCY);  // DUT takes it one edge later
    end
    @(negedge clk);
    sample_outputs();
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    while (exp_edge.size() > 0 && waited < WAIT_MAX) begin
      apply_cycle(1'b0, '0);
      waited++;
    end
    if (exp_edge.size() > 0) begin
      $display("timeout: %0d results never arrived within %0d cycles", exp_edge.size(),
               WAIT_MAX);
      err_cnt++;
      exp_leaf.delete();
      exp_edge.delete();
    end
    repeat (2) apply_cycle(1'b0, '0);  // Quiet tail, nothing may come out
  endtask

  // Negative selects every row
  task automatic run_rows(input int phase_sel);
    for (int r = 0; r < NUM_VEC; r++) begin
      if (phase_sel < 0 || int'(vectors[r].phase) == phase_sel) begin
        apply_cycle(vectors[r].en, vectors[r].patch);
      end
    end
    drain_results();
  endtask

  // Stream all NUM_NODES words, model follows only when load_mode is high
  task automatic load_tree(input logic lm);
    for (int n = 0; n < NUM_NODES; n++) begin
      @(posedge clk);
      edge_cnt++;
      load_mode <= lm;
      cfg_valid <= 1'b1;
      cfg_word  <= new_cfg[n];
      if (lm) begin
        model_cfg[n] = new_cfg[n];  // Breadth-first, root first
      end
    end
    @(posedge clk);
    edge_cnt++;
    load_mode <= 1'b0;
    cfg_valid <= 1'b0;
    cfg_word  <= '0;
  endtask

  task automatic finish_test(input int num, input string name);
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", num, name);
      tests_pass++;
    end else begin
      $display("test %0d %s: failed with %0d errors", num, name, err_cnt - errs_before);
      tests_fail++;
    end
    errs_before = err_cnt;
  endtask

  initial begin
    seed        = 18312;
    rst_n       = 1'b0;
    load_mode   = 1'b0;
    cfg_valid   = 1'b0;
    cfg_word    = '0;
    patch_en    = 1'b0;
    patch       = '0;
    edge_cnt    = 0;
    err_cnt     = 0;
    errs_before = 0;
    tests_pass  = 0;
    tests_fail  = 0;
    fill_table();
    reset_model();

    repeat (2) begin
      @(posedge clk);
      edge_cnt++;
    end
    rst_n <= 1'b1;

    run_rows(-1);  // Unloaded tree, all go right
    finish_test(1, "unloaded tree");

    build_config();
    load_tree(1'b0);  // Words without load_mode
    run_rows(-1);
    finish_test(2, "cfg ignored outside load mode");

    load_tree(1'b1);
    run_rows(-1);
    finish_test(3, "loaded tree");

    run_rows(int'(PH_BURST));
    finish_test(4, "back-to-back patches");

    run_rows(int'(PH_GAP));
    finish_test(5, "gaps in patch_en");

    build_config();
    load_tree(1'b1);  // Address wrapped, starts at the root again
    run_rows(-1);
    finish_test(6, "second load");

    $display("tests passed %0d, failed %0d, check errors %0d", tests_pass, tests_fail, err_cnt);
    if (tests_fail == 0 && err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
kd_pkg.sv
kd_internal_node.sv
kd_node_writer.sv
kd_search_tree.sv
kd_patch_classifier.sv
tb_kd_patch_classifier.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_kd_patch_classifier
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
